// File: common/icache_pkg.sv
package icache_pkg;

    // geometry
    localparam int line_count     = 8;
    localparam int line_halfwords = 16;
    localparam int index_width    = 3;
    localparam int offset_width   = 7;   // halfword index into the data array
    localparam int tag_width      = 10;
    localparam int csr_addr_width = 2;

    // csr word offsets
    localparam logic [csr_addr_width-1:0] csr_ctrl   = 2'd0;
    localparam logic [csr_addr_width-1:0] csr_hits   = 2'd1;
    localparam logic [csr_addr_width-1:0] csr_misses = 2'd2;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;   // high half from pc+2
    } fetch_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic        start;
        logic [31:0] addr;   // halfword aligned byte address
    } refill_cmd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [15:0] data;
        logic        last;
    } refill_beat_t;

    // address fields, tag 17..8, line 7..5, halfword 7..1
    function automatic logic [index_width-1:0] addr_index(input logic [31:0] addr);
        return addr[offset_width -: index_width];
    endfunction

    function automatic logic [offset_width-1:0] addr_offset(input logic [31:0] addr);
        return addr[offset_width:1];
    endfunction

    function automatic logic [tag_width-1:0] addr_tag(input logic [31:0] addr);
        return addr[offset_width+tag_width:offset_width+1];
    endfunction

endpackage

// File: icache/icache_core.sv
module icache_core
    import icache_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n,
    input  fetch_req_t   fetch_req,
    output fetch_rsp_t   fetch_rsp,
    output refill_cmd_t  refill_cmd,
    input  refill_beat_t refill_beat,
    input  logic         invalidate,
    output logic         hit_event,
    output logic         miss_event
);

    localparam int word_count = line_count * line_halfwords;

    typedef enum logic {
        st_lookup,
        st_wait
    } state_t;

    state_t state;

    logic [tag_width-1:0] tag_mem [line_count];
    logic [15:0]          data_mem [word_count];
    logic [word_count-1:0] valid_bits;

    logic [31:0] pc_lo;
    logic [31:0] pc_hi;
    logic        hit_lo;
    logic        hit_hi;
    logic        lookup;

    logic        rsp_valid;
    logic [31:0] rsp_inst;
    logic        start_q;
    logic [31:0] start_addr;
    logic        first_beat;   // next beat is the first of this refill

    logic [index_width-1:0]  beat_index;
    logic [offset_width-1:0] beat_offset;
    logic [tag_width-1:0]    beat_tag;
    logic                    tag_change;

    assign pc_lo = fetch_req.pc;
    assign pc_hi = fetch_req.pc + 32'd2;   // may fall in the next line

    assign hit_lo = valid_bits[addr_offset(pc_lo)] &&
                    tag_mem[addr_index(pc_lo)] == addr_tag(pc_lo);
    assign hit_hi = valid_bits[addr_offset(pc_hi)] &&
                    tag_mem[addr_index(pc_hi)] == addr_tag(pc_hi);

    // request is still held during the response cycle, skip it
    assign lookup = state == st_lookup && fetch_req.valid && !rsp_valid;

    assign beat_index  = addr_index(refill_beat.addr);
    assign beat_offset = addr_offset(refill_beat.addr);
    assign beat_tag    = addr_tag(refill_beat.addr);
    assign tag_change  = first_beat && tag_mem[beat_index] != beat_tag;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= st_lookup;
            rsp_valid  <= 1'b0;
            start_q    <= 1'b0;
            hit_event  <= 1'b0;
            miss_event <= 1'b0;
            first_beat <= 1'b0;
        end else begin
            rsp_valid  <= 1'b0;
            start_q    <= 1'b0;
            hit_event  <= 1'b0;
            miss_event <= 1'b0;
            case (state)
                st_lookup: begin
                    if (lookup) begin
                        if (hit_lo && hit_hi) begin
                            rsp_valid <= 1'b1;
                            hit_event <= 1'b1;
                        end else begin
                            start_q    <= 1'b1;
                            miss_event <= 1'b1;
                            first_beat <= 1'b1;
                            state      <= st_wait;
                        end
                    end
                end
                st_wait: begin
                    if (refill_beat.valid) begin
                        first_beat <= 1'b0;
                    end
                    if (refill_beat.valid && refill_beat.last) begin
                        state <= st_lookup;   // retry lookup next cycle
                    end
                end
                default: state <= st_lookup;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (lookup) begin
            rsp_inst   <= {data_mem[addr_offset(pc_hi)], data_mem[addr_offset(pc_lo)]};
            start_addr <= hit_lo ? pc_hi : pc_lo;   // pc half has priority
        end
    end

    always_ff @(posedge clk_in) begin
        if (refill_beat.valid) begin
            data_mem[beat_offset] <= refill_beat.data;
            if (first_beat) begin
                tag_mem[beat_index] <= beat_tag;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else begin
            if (invalidate) begin
                valid_bits <= '0;
            end
            if (refill_beat.valid) begin
                if (tag_change) begin
                    valid_bits[beat_index * line_halfwords +: line_halfwords] <= '0;
                end
                valid_bits[beat_offset] <= 1'b1;   // wins over the clears above
            end
        end
    end

    assign fetch_rsp  = '{valid: rsp_valid, inst: rsp_inst};
    assign refill_cmd = '{start: start_q, addr: start_addr};

    // one refill at a time, until the engine reports the line end
    assert property (@(posedge clk_in) disable iff (!rst_n)
        refill_cmd.start |=> !refill_cmd.start until_with
            (refill_beat.valid && refill_beat.last));

    assert property (@(posedge clk_in) disable iff (!rst_n)
        refill_beat.valid |-> state == st_wait);

endmodule

// File: icache/icache_refill.sv
module icache_refill
    import icache_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n,
    input  refill_cmd_t  refill_cmd,
    output refill_beat_t refill_beat,
    output wb_req_t      wb_req,
    input  wb_rsp_t      wb_rsp
);

    logic        busy;
    logic [31:0] addr;
    logic        line_end;
    logic        beat_done;

    logic        beat_valid;
    logic [31:0] beat_addr;
    logic [15:0] beat_data;
    logic        beat_last;

    // halfword 15 of the line
    assign line_end  = addr[offset_width-index_width:1] == '1;
    assign beat_done = busy && wb_rsp.ack;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= beat_done;
            if (refill_cmd.start) begin
                busy <= 1'b1;
            end else if (beat_done && line_end) begin
                busy <= 1'b0;   // drop cyc after the last beat
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (refill_cmd.start) begin
            addr <= {refill_cmd.addr[31:1], 1'b0};
        end else if (beat_done) begin
            addr <= addr + 32'd2;
        end
        if (beat_done) begin
            beat_addr <= addr;
            beat_data <= wb_rsp.dat_r[15:0];   // memory returns the halfword low
            beat_last <= line_end;
        end
    end

    assign wb_req = '{
        cyc:   busy,
        stb:   busy,
        we:    1'b0,
        adr:   addr,
        dat_w: 32'd0,
        sel:   addr[1] ? 4'b1100 : 4'b0011
    };

    assign refill_beat = '{
        valid: beat_valid,
        addr:  beat_addr,
        data:  beat_data,
        last:  beat_last
    };

    assert property (@(posedge clk_in) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

    assert property (@(posedge clk_in) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc);

endmodule

// File: verilog/icache_csr.sv
module icache_csr
    import icache_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    input  logic    hit_event,
    input  logic    miss_event,
    output logic    invalidate
);

    logic                      ack;
    logic [31:0]               dat_r;
    logic [31:0]               hits;
    logic [31:0]               misses;
    logic                      inval;
    logic [csr_addr_width-1:0] reg_sel;
    logic                      access;

    assign reg_sel = wb_req.adr[csr_addr_width+1:2];   // word offsets
    assign access  = wb_req.cyc && wb_req.stb && !ack;   // one ack per access

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            inval  <= 1'b0;
            hits   <= '0;
            misses <= '0;
        end else begin
            ack   <= access;
            // pulse lands the cycle after the write ack
            inval <= ack && wb_req.we && reg_sel == csr_ctrl && wb_req.dat_w[0];
            if (hit_event && hits != '1) begin
                hits <= hits + 32'd1;
            end
            if (miss_event && misses != '1) begin
                misses <= misses + 32'd1;
            end
        end
    end

    // counter writes fall through, ctrl reads as zero
    always_ff @(posedge clk_in) begin
        if (access) begin
            case (reg_sel)
                csr_hits:   dat_r <= hits;
                csr_misses: dat_r <= misses;
                default:    dat_r <= '0;
            endcase
        end
    end

    assign wb_rsp     = '{ack: ack, dat_r: dat_r};
    assign invalidate = inval;

    assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(wb_rsp.ack) |-> $past(wb_req.stb));

endmodule

// File: verilog/icache_top.sv
module icache_top
    import icache_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output wb_req_t    mem_wb_req,
    input  wb_rsp_t    mem_wb_rsp,
    input  wb_req_t    csr_wb_req,
    output wb_rsp_t    csr_wb_rsp
);

    refill_cmd_t  refill_cmd;
    refill_beat_t refill_beat;
    logic         hit_event;
    logic         miss_event;
    logic         invalidate;

    icache_core core0 (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .refill_cmd  (refill_cmd),
        .refill_beat (refill_beat),
        .invalidate  (invalidate),
        .hit_event   (hit_event),
        .miss_event  (miss_event)
    );

    // memory side master
    icache_refill refill0 (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .refill_cmd  (refill_cmd),
        .refill_beat (refill_beat),
        .wb_req      (mem_wb_req),
        .wb_rsp      (mem_wb_rsp)
    );

    icache_csr csr0 (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .wb_req      (csr_wb_req),
        .wb_rsp      (csr_wb_rsp),
        .hit_event   (hit_event),
        .miss_event  (miss_event),
        .invalidate  (invalidate)
    );

endmodule

// File: verification/tb_icache_mem.sv
module tb_icache_mem
    import icache_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    bus_error
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        ack;
    logic [31:0] dat_r;
    logic [1:0]  wait_left;   // idle cycles before the next ack
    logic        bad_beat;

    // contents computed from the address
    function automatic logic [15:0] half_at(input logic [31:0] addr);
        return addr[16:1] ^ 16'h5a5a;
    endfunction

    // reads only, with sel on the lane given by address bit 1
    assign bad_beat = wb_req.stb && (!wb_req.cyc || wb_req.we ||
                      wb_req.sel != (wb_req.adr[1] ? 4'b1100 : 4'b0011));

    always @(posedge clk_in) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            dat_r     <= '0;
            wait_left <= 2'($urandom_range(2, 0));
        end else if (ack) begin
            ack       <= 1'b0;   // stb in the ack cycle still belongs to this beat
            wait_left <= 2'($urandom_range(2, 0));
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_left == 2'd0) begin
                ack   <= 1'b1;
                // upper lane carries junk, the cache must take bits 15..0
                dat_r <= {~half_at(wb_req.adr), half_at(wb_req.adr)};
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(posedge clk_in) begin
        if (!rst_n) begin
            bus_error <= 1'b0;
        end else if (bad_beat) begin
            bus_error <= 1'b1;   // sticky
        end
    end

    assign wb_rsp = '{ack: ack, dat_r: dat_r};

endmodule

// File: verification/tb_icache.sv
module tb_icache
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cycles_per_request = 200;

    logic       clk_in = 1'b0;
    logic       rst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    wb_req_t    mem_wb_req;
    wb_rsp_t    mem_wb_rsp;
    wb_req_t    csr_wb_req;
    wb_rsp_t    csr_wb_rsp;
    logic       mem_error;

    // model of the tags and the per-halfword valid bits
    logic [9:0]   model_tag [8];
    logic [127:0] model_valid;

    string       test_name = "reset";
    logic [31:0] cur_pc = '0;
    int          requests = 0;
    int          responses = 0;
    int          cycle_count = 0;
    int          exp_hits = 0;
    int          exp_misses = 0;
    int          fail_count = 0;

    always #2 clk_in = ~clk_in;

    icache_top dut0 (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .mem_wb_req (mem_wb_req),
        .mem_wb_rsp (mem_wb_rsp),
        .csr_wb_req (csr_wb_req),
        .csr_wb_rsp (csr_wb_rsp)
    );

    tb_icache_mem mem0 (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .wb_req    (mem_wb_req),
        .wb_rsp    (mem_wb_rsp),
        .bus_error (mem_error)
    );

    function automatic logic [15:0] mem_half(input logic [31:0] addr);
        return addr[16:1] ^ 16'h5a5a;
    endfunction

    // pc+2 halfword above the pc halfword
    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        return {mem_half(pc + 32'd2), mem_half(pc)};
    endfunction

    function automatic logic model_hit(input logic [31:0] addr);
        return model_valid[addr[7:1]] && model_tag[addr[7:5]] == addr[17:8];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // from the missing halfword up to the line end
    task automatic model_refill(input logic [31:0] addr);
        int h;
        if (model_tag[addr[7:5]] != addr[17:8]) begin
            model_valid[addr[7:5] * 16 +: 16] = '0;
        end
        model_tag[addr[7:5]] = addr[17:8];
        for (h = addr[4:1]; h < 16; h++) begin
            model_valid[{addr[7:5], 4'(h)}] = 1'b1;
        end
    endtask

    task automatic predict_fetch(input logic [31:0] pc, output int misses);
        misses = 0;
        while (!(model_hit(pc) && model_hit(pc + 32'd2)) && misses < 3) begin
            model_refill(model_hit(pc) ? pc + 32'd2 : pc);   // pc half first
            misses++;
        end
    endtask

    task automatic run_fetch(input string name, input logic [31:0] pc);
        int misses;
        int cycles;
        predict_fetch(pc, misses);
        exp_misses += misses;
        exp_hits++;   // the final lookup always hits
        test_name = name;
        cur_pc = pc;
        @(posedge clk_in);
        fetch_req <= '{valid: 1'b1, pc: pc};
        requests++;
        cycles = 0;
        do begin
            @(posedge clk_in);
            cycles++;
            @(negedge clk_in);
        end while (!fetch_rsp.valid);
        // a hit answers one cycle after the request
        check_value({name, " timing"}, 32'(misses == 0), 32'(cycles == 1));
        @(posedge clk_in);
        fetch_req <= '{valid: 1'b0, pc: 32'd0};
    endtask

    task automatic csr_access(input logic we, input logic [1:0] offset,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk_in);
        csr_wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: {28'd0, offset, 2'b00},
                        dat_w: wdata, sel: 4'hf};
        requests++;
        do begin
            @(negedge clk_in);
        end while (!csr_wb_rsp.ack);
        rdata = csr_wb_rsp.dat_r;
        @(posedge clk_in);
        csr_wb_req <= '0;
    endtask

    // compare every response
    always @(negedge clk_in) begin
        if (rst_n) begin
            check_value("memory bus protocol", 32'd0, 32'(mem_error));
            if (fetch_rsp.valid) begin
                responses++;
                check_value(test_name, expected_inst(cur_pc), fetch_rsp.inst);
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count > cycles_per_request * (requests + 1)) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] misses_before;
        int i;
        void'($urandom(33));
        rst_n = 1'b0;
        fetch_req = '0;
        csr_wb_req = '0;
        model_valid = '0;
        foreach (model_tag[k]) begin
            model_tag[k] = '0;
        end
        repeat (10) @(posedge clk_in);
        rst_n <= 1'b1;

        run_fetch("cold fetch", 32'h0000_0400);
        run_fetch("repeat fetch", 32'h0000_0400);

        // halfword 15, pc+2 in the next line
        csr_access(1'b0, csr_misses, 32'd0, misses_before);
        run_fetch("line straddle", 32'h0000_05fe);
        csr_access(1'b0, csr_misses, 32'd0, rdata);
        check_value("straddle miss count", 32'd2, rdata - misses_before);

        run_fetch("old tag", 32'h0000_0440);
        run_fetch("new tag", 32'h0000_0840);
        run_fetch("old tag again", 32'h0000_0444);

        run_fetch("before invalidate", 32'h0000_0480);
        run_fetch("cached", 32'h0000_0480);
        csr_access(1'b1, csr_ctrl, 32'd1, rdata);
        model_valid = '0;
        run_fetch("after invalidate", 32'h0000_0480);

        for (i = 0; i < 200; i++) begin
            run_fetch($sformatf("random %0d", i),
                      32'h0000_1000 + 32'($urandom_range(511, 0)) * 32'd2);
        end

        csr_access(1'b0, csr_hits, 32'd0, rdata);
        check_value("hit count", 32'(exp_hits), rdata);
        csr_access(1'b0, csr_misses, 32'd0, rdata);
        check_value("miss count", 32'(exp_misses), rdata);
        check_value("response count", 32'(exp_hits), 32'(responses));

        repeat (5) @(posedge clk_in);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
common/icache_pkg.sv
icache/icache_core.sv
icache/icache_refill.sv
verilog/icache_csr.sv
verilog/icache_top.sv
verification/tb_icache_mem.sv
verification/tb_icache.sv
